//--- all.f
+incdir+rtl
rtl/engine_pkg.sv
rtl/rename_map.sv
rtl/free_list.sv
rtl/reg_status_table.sv
rtl/phys_reg_file.sv
rtl/retire_queue.sv
rtl/engine.sv
verification/engine_tb.sv

//--- rtl/engine.sv
// --------------------------------------------------------------------------
// Rename and retire core of a two-wide out-of-order engine. Renames a
// bundle per cycle, tracks ready bits and commits in order
// --------------------------------------------------------------------------
`timescale 1ns/1ns

module engine (
  input  logic                core_clock_i,
  input  logic                reset_i,
  input  logic                valid_i,
  input  logic                ins1_valid_i,
  input  logic                ins0_wr_i,
  input  logic                ins1_wr_i,
  input  engine_pkg::areg_t   ins0_rs1_i,
  input  engine_pkg::areg_t   ins0_rs2_i,
  input  engine_pkg::areg_t   ins0_dest_i,
  input  engine_pkg::areg_t   ins1_rs1_i,
  input  engine_pkg::areg_t   ins1_rs2_i,
  input  engine_pkg::areg_t   ins1_dest_i,
  output logic                rn_busy_o,
  output logic                rn_valid_o,
  output engine_pkg::preg_t   ins0_rs1_preg_o,
  output engine_pkg::preg_t   ins0_rs2_preg_o,
  output engine_pkg::preg_t   ins1_rs1_preg_o,
  output engine_pkg::preg_t   ins1_rs2_preg_o,
  output engine_pkg::preg_t   ins0_dest_preg_o,
  output engine_pkg::preg_t   ins1_dest_preg_o,
  output engine_pkg::rob_id_t ins0_slot_o,
  output engine_pkg::rob_id_t ins1_slot_o,
  input  logic                wb0_we_i,
  input  engine_pkg::preg_t   wb0_dest_i,
  input  engine_pkg::xword_t  wb0_data_i,
  input  logic                wb1_we_i,
  input  engine_pkg::preg_t   wb1_dest_i,
  input  engine_pkg::xword_t  wb1_data_i,
  input  logic                cmp0_i,
  input  engine_pkg::rob_id_t cmp0_slot_i,
  input  logic                cmp1_i,
  input  engine_pkg::rob_id_t cmp1_slot_i,
  input  engine_pkg::preg_t   p0_rd_src_i,
  output engine_pkg::xword_t  p0_rd_data_o,
  input  engine_pkg::preg_t   p1_rd_src_i,
  output engine_pkg::xword_t  p1_rd_data_o,
  input  engine_pkg::preg_t   r0_preg_i,
  output logic                r0_o,
  input  engine_pkg::preg_t   r1_preg_i,
  output logic                r1_o,
  output logic                commit0_o,
  output logic                commit1_o
);
  import engine_pkg::*;

  logic    accept;
  logic    alloc0;
  logic    alloc1;
  logic    fl_low;
  logic    rq_full;
  logic    free0;
  logic    free1;
  preg_t   fl_head0;
  preg_t   fl_head1;
  preg_t   new0_preg;
  preg_t   new1_preg;
  preg_t   map_rs1_0;
  preg_t   map_rs2_0;
  preg_t   map_rs1_1;
  preg_t   map_rs2_1;
  preg_t   old0_preg;
  preg_t   old1_preg;
  preg_t   free0_preg;
  preg_t   free1_preg;
  rob_id_t tail_slot;

  // Busy depends on stored state only, never on the bundle offered
  assign rn_busy_o = fl_low | rq_full;
  assign accept    = valid_i & ~rn_busy_o;

  // Writes to x0 take no physical register
  assign alloc0 = accept & ins0_wr_i & (ins0_dest_i != '0);
  assign alloc1 = accept & ins1_valid_i & ins1_wr_i & (ins1_dest_i != '0);

  // Instruction 1 takes head1 only when instruction 0 already took head0
  assign new0_preg = fl_head0;
  assign new1_preg = alloc0 ? fl_head1 : fl_head0;

  rename_map rename_map_i (
    .core_clock_i    (core_clock_i),
    .reset_i         (reset_i),
    .alloc0_i        (alloc0),
    .alloc1_i        (alloc1),
    .ins0_rs1_i      (ins0_rs1_i),
    .ins0_rs2_i      (ins0_rs2_i),
    .ins0_dest_i     (ins0_dest_i),
    .ins1_rs1_i      (ins1_rs1_i),
    .ins1_rs2_i      (ins1_rs2_i),
    .ins1_dest_i     (ins1_dest_i),
    .new0_preg_i     (new0_preg),
    .new1_preg_i     (new1_preg),
    .ins0_rs1_preg_o (map_rs1_0),
    .ins0_rs2_preg_o (map_rs2_0),
    .ins1_rs1_preg_o (map_rs1_1),
    .ins1_rs2_preg_o (map_rs2_1),
    .old0_preg_o     (old0_preg),
    .old1_preg_o     (old1_preg)
  );

  free_list free_list_i (
    .core_clock_i (core_clock_i),
    .reset_i      (reset_i),
    .pop0_i       (alloc0),
    .pop1_i       (alloc1),
    .push0_i      (free0),
    .push1_i      (free1),
    .push0_preg_i (free0_preg),
    .push1_preg_i (free1_preg),
    .head0_preg_o (fl_head0),
    .head1_preg_o (fl_head1),
    .low_o        (fl_low)
  );

  reg_status_table reg_status_table_i (
    .core_clock_i (core_clock_i),
    .reset_i      (reset_i),
    .clr0_i       (alloc0),
    .clr1_i       (alloc1),
    .set0_i       (wb0_we_i),
    .set1_i       (wb1_we_i),
    .clr0_preg_i  (new0_preg),
    .clr1_preg_i  (new1_preg),
    .set0_preg_i  (wb0_dest_i),
    .set1_preg_i  (wb1_dest_i),
    .r0_preg_i    (r0_preg_i),
    .r1_preg_i    (r1_preg_i),
    .r0_o         (r0_o),
    .r1_o         (r1_o)
  );

  phys_reg_file phys_reg_file_i (
    .core_clock_i (core_clock_i),
    .we0_i        (wb0_we_i),
    .we1_i        (wb1_we_i),
    .wdest0_i     (wb0_dest_i),
    .wdest1_i     (wb1_dest_i),
    .rsrc0_i      (p0_rd_src_i),
    .rsrc1_i      (p1_rd_src_i),
    .wdata0_i     (wb0_data_i),
    .wdata1_i     (wb1_data_i),
    .rdata0_o     (p0_rd_data_o),
    .rdata1_o     (p1_rd_data_o)
  );

  retire_queue retire_queue_i (
    .core_clock_i (core_clock_i),
    .reset_i      (reset_i),
    .push_i       (accept),
    .ins1_i       (ins1_valid_i),
    .alloc0_i     (alloc0),
    .alloc1_i     (alloc1),
    .cmp0_i       (cmp0_i),
    .cmp1_i       (cmp1_i),
    .old0_preg_i  (old0_preg),
    .old1_preg_i  (old1_preg),
    .cmp0_slot_i  (cmp0_slot_i),
    .cmp1_slot_i  (cmp1_slot_i),
    .tail_slot_o  (tail_slot),
    .full_o       (rq_full),
    .commit0_o    (commit0_o),
    .commit1_o    (commit1_o),
    .free0_o      (free0),
    .free1_o      (free1),
    .free0_preg_o (free0_preg),
    .free1_preg_o (free1_preg)
  );

  always_ff @(posedge core_clock_i) begin
    if (reset_i) begin
      rn_valid_o <= 1'b0;
    end else begin
      rn_valid_o <= accept;
    end
  end

  // Rename results are held until the next accepted bundle
  always_ff @(posedge core_clock_i) begin
    if (accept) begin
      ins0_rs1_preg_o  <= map_rs1_0;
      ins0_rs2_preg_o  <= map_rs2_0;
      ins1_rs1_preg_o  <= map_rs1_1;
      ins1_rs2_preg_o  <= map_rs2_1;
      ins0_dest_preg_o <= alloc0 ? new0_preg : '0;
      ins1_dest_preg_o <= alloc1 ? new1_preg : '0;
      ins0_slot_o      <= tail_slot;
      ins1_slot_o      <= tail_slot + rob_id_t'(1);
    end
  end

endmodule

//--- rtl/engine_defines.svh
// --------------------------------------------------------------------------
// Engine dimensions shared by the package and the RTL blocks: register
// counts, retire queue depth and data word width
// --------------------------------------------------------------------------
`ifndef ENGINE_DEFINES_SVH
`define ENGINE_DEFINES_SVH

// Architectural integer registers, x0 included
`define ENGINE_NUM_AREGS 32

// Physical registers behind the rename map
`define ENGINE_NUM_PREGS 64

// Slots in the in-order retire queue
`define ENGINE_ROB_DEPTH 16

// Width of one data word in the register file
`define ENGINE_XLEN 32

`endif

//--- rtl/engine_pkg.sv
// --------------------------------------------------------------------------
// Engine package. Index and data types shared by the rename, status,
// register file and retire blocks
// --------------------------------------------------------------------------
`include "engine_defines.svh"

package engine_pkg;

  // Architectural register index, x0 to x31
  typedef logic [$clog2(`ENGINE_NUM_AREGS)-1:0] areg_t;

  // Physical register index
  typedef logic [$clog2(`ENGINE_NUM_PREGS)-1:0] preg_t;

  // Retire queue slot index, wraps at the queue depth
  typedef logic [$clog2(`ENGINE_ROB_DEPTH)-1:0] rob_id_t;

  // One data word as held in the physical register file
  typedef logic [`ENGINE_XLEN-1:0] xword_t;

endpackage

//--- rtl/free_list.sv
// --------------------------------------------------------------------------
// Free physical register list. Circular queue that hands out up to two
// registers and takes back up to two released registers per cycle
// --------------------------------------------------------------------------
`timescale 1ns/1ns
`include "engine_defines.svh"

module free_list (
  input  logic              core_clock_i,
  input  logic              reset_i,
  input  logic              pop0_i,
  input  logic              pop1_i,
  input  logic              push0_i,
  input  logic              push1_i,
  input  engine_pkg::preg_t push0_preg_i,
  input  engine_pkg::preg_t push1_preg_i,
  output engine_pkg::preg_t head0_preg_o,
  output engine_pkg::preg_t head1_preg_o,
  output logic              low_o
);
  import engine_pkg::*;

  localparam int INIT_FREE = `ENGINE_NUM_PREGS - `ENGINE_NUM_AREGS;

  preg_t      fl_q [`ENGINE_NUM_PREGS];
  preg_t      head_q;
  preg_t      tail_q;
  logic [6:0] count_q;
  logic [1:0] pop_n;
  logic [1:0] push_n;

  assign pop_n  = {1'b0, pop0_i} + {1'b0, pop1_i};
  assign push_n = {1'b0, push0_i} + {1'b0, push1_i};

  // The two oldest entries are always on view. A lone pop takes head0
  // whichever instruction asks for it
  assign head0_preg_o = fl_q[head_q];
  assign head1_preg_o = fl_q[head_q + preg_t'(1)];

  // Rename needs two registers on hand to accept any bundle
  assign low_o = (count_q < 7'd2);

  always_ff @(posedge core_clock_i) begin
    if (reset_i) begin
      // Registers above the identity map start out free, lowest first
      for (int i = 0; i < INIT_FREE; i++) begin
        fl_q[i] <= preg_t'(i + `ENGINE_NUM_AREGS);
      end
      head_q  <= '0;
      tail_q  <= preg_t'(INIT_FREE);
      count_q <= 7'(INIT_FREE);
    end else begin
      if (push0_i) begin
        fl_q[tail_q] <= push0_preg_i;
      end
      if (push1_i) begin
        fl_q[tail_q + preg_t'(push0_i)] <= push1_preg_i;
      end
      head_q  <= head_q + preg_t'(pop_n);
      tail_q  <= tail_q + preg_t'(push_n);
      count_q <= count_q + 7'(push_n) - 7'(pop_n);
    end
  end

endmodule

//--- rtl/phys_reg_file.sv
// --------------------------------------------------------------------------
// Physical register file. 64 words, two write ports from the execution
// units and two combinational read ports
// --------------------------------------------------------------------------
`timescale 1ns/1ns
`include "engine_defines.svh"

module phys_reg_file (
  input  logic               core_clock_i,
  input  logic               we0_i,
  input  logic               we1_i,
  input  engine_pkg::preg_t  wdest0_i,
  input  engine_pkg::preg_t  wdest1_i,
  input  engine_pkg::preg_t  rsrc0_i,
  input  engine_pkg::preg_t  rsrc1_i,
  input  engine_pkg::xword_t wdata0_i,
  input  engine_pkg::xword_t wdata1_i,
  output engine_pkg::xword_t rdata0_o,
  output engine_pkg::xword_t rdata1_o
);
  import engine_pkg::*;

  xword_t regs_q [`ENGINE_NUM_PREGS];

  // No write-through, a same-cycle read returns the old word
  assign rdata0_o = regs_q[rsrc0_i];
  assign rdata1_o = regs_q[rsrc1_i];

  always_ff @(posedge core_clock_i) begin
    if (we0_i) begin
      regs_q[wdest0_i] <= wdata0_i;
    end
    // Port 1 is written last and wins on a collision
    if (we1_i) begin
      regs_q[wdest1_i] <= wdata1_i;
    end
  end

endmodule

//--- rtl/reg_status_table.sv
// --------------------------------------------------------------------------
// Register status table. One ready bit per physical register, cleared on
// rename and set on writeback
// --------------------------------------------------------------------------
`timescale 1ns/1ns
`include "engine_defines.svh"

module reg_status_table (
  input  logic              core_clock_i,
  input  logic              reset_i,
  input  logic              clr0_i,
  input  logic              clr1_i,
  input  logic              set0_i,
  input  logic              set1_i,
  input  engine_pkg::preg_t clr0_preg_i,
  input  engine_pkg::preg_t clr1_preg_i,
  input  engine_pkg::preg_t set0_preg_i,
  input  engine_pkg::preg_t set1_preg_i,
  input  engine_pkg::preg_t r0_preg_i,
  input  engine_pkg::preg_t r1_preg_i,
  output logic              r0_o,
  output logic              r1_o
);
  import engine_pkg::*;

  logic [`ENGINE_NUM_PREGS-1:0] rdy_q;

  // Queries see the stored bits, so an update shows up a cycle later
  assign r0_o = rdy_q[r0_preg_i];
  assign r1_o = rdy_q[r1_preg_i];

  always_ff @(posedge core_clock_i) begin
    if (reset_i) begin
      // Only the registers behind the identity map hold valid values
      for (int i = 0; i < `ENGINE_NUM_PREGS; i++) begin
        rdy_q[i] <= (i < `ENGINE_NUM_AREGS);
      end
    end else begin
      if (set0_i) begin
        rdy_q[set0_preg_i] <= 1'b1;
      end
      if (set1_i) begin
        rdy_q[set1_preg_i] <= 1'b1;
      end
      // Clears come after sets so a freshly allocated register stays busy
      if (clr0_i) begin
        rdy_q[clr0_preg_i] <= 1'b0;
      end
      if (clr1_i) begin
        rdy_q[clr1_preg_i] <= 1'b0;
      end
    end
  end

endmodule

//--- rtl/rename_map.sv
// --------------------------------------------------------------------------
// Rename map table. Translates architectural to physical registers for a
// two-wide bundle and forwards instruction 0's new register to instruction 1
// --------------------------------------------------------------------------
`timescale 1ns/1ns
`include "engine_defines.svh"

module rename_map (
  input  logic              core_clock_i,
  input  logic              reset_i,
  input  logic              alloc0_i,
  input  logic              alloc1_i,
  input  engine_pkg::areg_t ins0_rs1_i,
  input  engine_pkg::areg_t ins0_rs2_i,
  input  engine_pkg::areg_t ins0_dest_i,
  input  engine_pkg::areg_t ins1_rs1_i,
  input  engine_pkg::areg_t ins1_rs2_i,
  input  engine_pkg::areg_t ins1_dest_i,
  input  engine_pkg::preg_t new0_preg_i,
  input  engine_pkg::preg_t new1_preg_i,
  output engine_pkg::preg_t ins0_rs1_preg_o,
  output engine_pkg::preg_t ins0_rs2_preg_o,
  output engine_pkg::preg_t ins1_rs1_preg_o,
  output engine_pkg::preg_t ins1_rs2_preg_o,
  output engine_pkg::preg_t old0_preg_o,
  output engine_pkg::preg_t old1_preg_o
);
  import engine_pkg::*;

  preg_t map_q [`ENGINE_NUM_AREGS];
  logic  dep_rs1;
  logic  dep_rs2;
  logic  dep_dest;

  // Instruction 1 depends on instruction 0 when it names the register
  // that instruction 0 is renaming in this same bundle
  assign dep_rs1  = alloc0_i && (ins1_rs1_i == ins0_dest_i);
  assign dep_rs2  = alloc0_i && (ins1_rs2_i == ins0_dest_i);
  assign dep_dest = alloc0_i && (ins1_dest_i == ins0_dest_i);

  assign ins0_rs1_preg_o = map_q[ins0_rs1_i];
  assign ins0_rs2_preg_o = map_q[ins0_rs2_i];
  assign ins1_rs1_preg_o = dep_rs1 ? new0_preg_i : map_q[ins1_rs1_i];
  assign ins1_rs2_preg_o = dep_rs2 ? new0_preg_i : map_q[ins1_rs2_i];

  // Old mappings go to the retire queue and are freed at commit
  assign old0_preg_o = map_q[ins0_dest_i];
  assign old1_preg_o = dep_dest ? new0_preg_i : map_q[ins1_dest_i];

  always_ff @(posedge core_clock_i) begin
    if (reset_i) begin
      // Identity mapping, x0 to p0 and so on
      for (int i = 0; i < `ENGINE_NUM_AREGS; i++) begin
        map_q[i] <= preg_t'(i);
      end
    end else begin
      if (alloc0_i) begin
        map_q[ins0_dest_i] <= new0_preg_i;
      end
      // Written last, so instruction 1 wins on a shared destination
      if (alloc1_i) begin
        map_q[ins1_dest_i] <= new1_preg_i;
      end
    end
  end

endmodule

//--- rtl/retire_queue.sv
// --------------------------------------------------------------------------
// Retire queue. Keeps renamed instructions in program order, collects
// completions by slot and commits up to two per cycle from the head
// --------------------------------------------------------------------------
`timescale 1ns/1ns
`include "engine_defines.svh"

module retire_queue (
  input  logic                core_clock_i,
  input  logic                reset_i,
  input  logic                push_i,
  input  logic                ins1_i,
  input  logic                alloc0_i,
  input  logic                alloc1_i,
  input  logic                cmp0_i,
  input  logic                cmp1_i,
  input  engine_pkg::preg_t   old0_preg_i,
  input  engine_pkg::preg_t   old1_preg_i,
  input  engine_pkg::rob_id_t cmp0_slot_i,
  input  engine_pkg::rob_id_t cmp1_slot_i,
  output engine_pkg::rob_id_t tail_slot_o,
  output logic                full_o,
  output logic                commit0_o,
  output logic                commit1_o,
  output logic                free0_o,
  output logic                free1_o,
  output engine_pkg::preg_t   free0_preg_o,
  output engine_pkg::preg_t   free1_preg_o
);
  import engine_pkg::*;

  logic [`ENGINE_ROB_DEPTH-1:0] alloc_q;
  logic [`ENGINE_ROB_DEPTH-1:0] done_q;
  preg_t                        old_q [`ENGINE_ROB_DEPTH];
  rob_id_t                      head_q;
  rob_id_t                      tail_q;
  rob_id_t                      head1;
  rob_id_t                      tail1;
  logic [4:0]                   count_q;
  logic                         push1;
  logic                         commit_a;
  logic                         commit_b;
  logic [1:0]                   push_n;
  logic [1:0]                   commit_n;

  assign head1  = head_q + rob_id_t'(1);
  assign tail1  = tail_q + rob_id_t'(1);
  assign push1  = push_i & ins1_i;
  assign push_n = {1'b0, push_i} + {1'b0, push1};

  // Occupancy guards keep stale done bits of empty slots out of commit
  assign commit_a = (count_q != '0) && done_q[head_q];
  assign commit_b = commit_a && (count_q > 5'd1) && done_q[head1];
  assign commit_n = {1'b0, commit_a} + {1'b0, commit_b};

  // A bundle may need two slots
  assign full_o      = (count_q > 5'(`ENGINE_ROB_DEPTH - 2));
  assign tail_slot_o = tail_q;

  // Old mappings return to the free list at the commit edge
  assign free0_o      = commit_a & alloc_q[head_q];
  assign free1_o      = commit_b & alloc_q[head1];
  assign free0_preg_o = old_q[head_q];
  assign free1_preg_o = old_q[head1];

  always_ff @(posedge core_clock_i) begin
    if (reset_i) begin
      head_q    <= '0;
      tail_q    <= '0;
      count_q   <= '0;
      done_q    <= '0;
      commit0_o <= 1'b0;
      commit1_o <= 1'b0;
    end else begin
      if (push_i) begin
        done_q[tail_q] <= 1'b0;
      end
      if (push1) begin
        done_q[tail1] <= 1'b0;
      end
      if (cmp0_i) begin
        done_q[cmp0_slot_i] <= 1'b1;
      end
      if (cmp1_i) begin
        done_q[cmp1_slot_i] <= 1'b1;
      end
      head_q    <= head_q + rob_id_t'(commit_n);
      tail_q    <= tail_q + rob_id_t'(push_n);
      count_q   <= count_q + 5'(push_n) - 5'(commit_n);
      commit0_o <= commit_a;
      commit1_o <= commit_b;
    end
  end

  always_ff @(posedge core_clock_i) begin
    if (push_i) begin
      alloc_q[tail_q] <= alloc0_i;
      old_q[tail_q]   <= old0_preg_i;
    end
    if (push1) begin
      alloc_q[tail1] <= alloc1_i;
      old_q[tail1]   <= old1_preg_i;
    end
  end

endmodule

//--- run.sh
#!/bin/sh
# Build the engine testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary -Wno-fatal -f all.f --top-module engine_tb -Mdir obj_dir -o engine_sim \
  || { echo "Verilator build failed"; exit 1; }
out=$(./obj_dir/engine_sim)
echo "$out"
echo "$out" | grep -qx "RESULT: PASS" && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

//--- verification/engine_tb.sv
// --------------------------------------------------------------------------
// Testbench for the rename and retire engine. Random bundles, writebacks and
// completions are checked against a model of map, free list and retire queue
// --------------------------------------------------------------------------
`timescale 1ns/1ns
`include "engine_defines.svh"

module engine_tb;
  import engine_pkg::*;

  localparam int RST_CYCLES   = 8;
  localparam int SWEEP_CYCLES = `ENGINE_NUM_PREGS / 2;
  localparam int RAND_CYCLES  = 1200;
  localparam int BP_CYCLES    = 60;
  localparam int DRAIN_CYCLES = 200;
  localparam int MAX_CYCLES   =
    2 * (RST_CYCLES + SWEEP_CYCLES + RAND_CYCLES + BP_CYCLES + DRAIN_CYCLES);
  localparam int DEPTH        = `ENGINE_ROB_DEPTH;

  logic    core_clock_i, reset_i, valid_i, ins1_valid_i, ins0_wr_i, ins1_wr_i;
  areg_t   ins0_rs1_i, ins0_rs2_i, ins0_dest_i, ins1_rs1_i, ins1_rs2_i, ins1_dest_i;
  logic    rn_busy_o, rn_valid_o, r0_o, r1_o, commit0_o, commit1_o;
  preg_t   ins0_rs1_preg_o, ins0_rs2_preg_o, ins1_rs1_preg_o, ins1_rs2_preg_o;
  preg_t   ins0_dest_preg_o, ins1_dest_preg_o;
  rob_id_t ins0_slot_o, ins1_slot_o, cmp0_slot_i, cmp1_slot_i;
  logic    wb0_we_i, wb1_we_i, cmp0_i, cmp1_i;
  preg_t   wb0_dest_i, wb1_dest_i, p0_rd_src_i, p1_rd_src_i, r0_preg_i, r1_preg_i;
  xword_t  wb0_data_i, wb1_data_i, p0_rd_data_o, p1_rd_data_o;

  // Reference model state
  preg_t      m_map [`ENGINE_NUM_AREGS];
  preg_t      m_fl [$];
  logic       m_rdy [`ENGINE_NUM_PREGS];
  logic       m_known [`ENGINE_NUM_PREGS];
  xword_t     m_rf [`ENGINE_NUM_PREGS];
  logic       m_rq_alloc [DEPTH];
  logic       m_rq_done [DEPTH];
  preg_t      m_rq_old [DEPTH];
  int         m_rq_head, m_rq_count;
  // Renamed but not yet completed entries as {dest preg, slot}
  logic [9:0] pending [$];

  logic        exp_valid = 1'b0, exp_c0 = 1'b0, exp_c1 = 1'b0, exp_ins1 = 1'b0;
  logic [35:0] exp_rn;
  rob_id_t     exp_slot0;
  logic        model_live = 1'b0;
  int errors = 0, checks = 0, cycles = 0, n_insts = 0, n_commits = 0;

  engine engine_i (.*);

  always #20 core_clock_i = ~core_clock_i;

  task automatic check(input logic [63:0] got, input logic [63:0] exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  // Rename accepts nothing unless two registers and two slots are on hand
  function automatic logic busy_ref();
    return (m_fl.size() < 2) || ((DEPTH - m_rq_count) < 2);
  endfunction

  // Expected {rs1_0, rs2_0, rs1_1, rs2_1, dest0, dest1} for the bundle on the inputs
  function automatic logic [35:0] rename_ref(input logic a0, input logic a1);
    preg_t n0;
    preg_t n1;
    preg_t s1;
    preg_t s2;
    n0 = a0 ? m_fl[0] : preg_t'(0);
    n1 = !a1 ? preg_t'(0) : (a0 ? m_fl[1] : m_fl[0]);
    s1 = (a0 && ins1_rs1_i == ins0_dest_i) ? n0 : m_map[ins1_rs1_i];
    s2 = (a0 && ins1_rs2_i == ins0_dest_i) ? n0 : m_map[ins1_rs2_i];
    return {m_map[ins0_rs1_i], m_map[ins0_rs2_i], s1, s2, n0, n1};
  endfunction

  always @(posedge core_clock_i) begin : model
    logic acc, a0, a1, c0, c1;
    preg_t n0, n1, old0, old1;
    int tail;
    if (reset_i) begin
      m_fl.delete();
      pending.delete();
      for (int i = 0; i < `ENGINE_NUM_AREGS; i++) begin
        m_map[i] = preg_t'(i);
        m_fl.push_back(preg_t'(i + `ENGINE_NUM_AREGS));
      end
      for (int i = 0; i < `ENGINE_NUM_PREGS; i++) begin
        m_rdy[i]   = (i < `ENGINE_NUM_AREGS);
        m_known[i] = 1'b0;
      end
      for (int i = 0; i < DEPTH; i++) begin
        m_rq_done[i] = 1'b0;
      end
      m_rq_head  = 0;
      m_rq_count = 0;
      exp_valid  = 1'b0;
      exp_c0     = 1'b0;
      exp_c1     = 1'b0;
      model_live = 1'b1;
    end else begin
      acc = valid_i && !busy_ref();
      a0  = acc && ins0_wr_i && (ins0_dest_i != 0);
      a1  = acc && ins1_valid_i && ins1_wr_i && (ins1_dest_i != 0);
      exp_valid = acc;
      if (acc) begin
        exp_rn    = rename_ref(a0, a1);
        exp_slot0 = rob_id_t'(m_rq_head + m_rq_count);
        exp_ins1  = ins1_valid_i;
      end
      n0 = exp_rn[11:6];
      n1 = exp_rn[5:0];
      if (a0) void'(m_fl.pop_front());
      if (a1) void'(m_fl.pop_front());
      // Commit looks at the done bits from before this edge
      c0 = (m_rq_count > 0) && m_rq_done[m_rq_head];
      c1 = c0 && (m_rq_count > 1) && m_rq_done[(m_rq_head + 1) % DEPTH];
      exp_c0 = c0;
      exp_c1 = c1;
      for (int k = 0; k < 2; k++) begin
        if ((k == 0) ? c0 : c1) begin
          if (m_rq_alloc[m_rq_head]) m_fl.push_back(m_rq_old[m_rq_head]);
          m_rq_head  = (m_rq_head + 1) % DEPTH;
          m_rq_count = m_rq_count - 1;
        end
      end
      if (wb0_we_i) begin
        m_rf[wb0_dest_i]    = wb0_data_i;
        m_known[wb0_dest_i] = 1'b1;
        m_rdy[wb0_dest_i]   = 1'b1;
      end
      if (wb1_we_i) begin
        m_rf[wb1_dest_i]    = wb1_data_i;
        m_known[wb1_dest_i] = 1'b1;
        m_rdy[wb1_dest_i]   = 1'b1;
      end
      if (cmp0_i) m_rq_done[cmp0_slot_i] = 1'b1;
      if (cmp1_i) m_rq_done[cmp1_slot_i] = 1'b1;
      if (acc) begin
        // Sequential map update gives instruction 1 the bypassed old register
        old0 = m_map[ins0_dest_i];
        if (a0) m_map[ins0_dest_i] = n0;
        old1 = m_map[ins1_dest_i];
        if (a1) m_map[ins1_dest_i] = n1;
        tail = (m_rq_head + m_rq_count) % DEPTH;
        m_rq_alloc[tail] = a0;
        m_rq_old[tail]   = old0;
        m_rq_done[tail]  = 1'b0;
        pending.push_back({n0, rob_id_t'(tail)});
        if (a0) m_rdy[n0] = 1'b0;
        if (ins1_valid_i) begin
          tail = (tail + 1) % DEPTH;
          m_rq_alloc[tail] = a1;
          m_rq_old[tail]   = old1;
          m_rq_done[tail]  = 1'b0;
          pending.push_back({n1, rob_id_t'(tail)});
          if (a1) m_rdy[n1] = 1'b0;
        end
        m_rq_count = m_rq_count + (ins1_valid_i ? 2 : 1);
        n_insts    = n_insts + (ins1_valid_i ? 2 : 1);
      end
    end
  end

  // Outputs are compared half a cycle after the edge that produced them
  always @(negedge core_clock_i) begin
    if (model_live) begin
      check(rn_busy_o, busy_ref(), "rn_busy_o");
      check(rn_valid_o, exp_valid, "rn_valid_o");
      if (exp_valid) begin
        check({ins0_rs1_preg_o, ins0_rs2_preg_o}, exp_rn[35:24], "ins0 source pregs");
        check(ins0_dest_preg_o, exp_rn[11:6], "ins0_dest_preg_o");
        check(ins0_slot_o, exp_slot0, "ins0_slot_o");
        if (exp_ins1) begin
          check({ins1_rs1_preg_o, ins1_rs2_preg_o}, exp_rn[23:12], "ins1 source pregs");
          check(ins1_dest_preg_o, exp_rn[5:0], "ins1_dest_preg_o");
          check(ins1_slot_o, rob_id_t'(exp_slot0 + 1), "ins1_slot_o");
        end
      end
      check(commit0_o, exp_c0, "commit0_o");
      check(commit1_o, exp_c1, "commit1_o");
      check(r0_o, m_rdy[r0_preg_i], "r0_o");
      check(r1_o, m_rdy[r1_preg_i], "r1_o");
      if (m_known[p0_rd_src_i]) check(p0_rd_data_o, m_rf[p0_rd_src_i], "p0_rd_data_o");
      if (m_known[p1_rd_src_i]) check(p1_rd_data_o, m_rf[p1_rd_src_i], "p1_rd_data_o");
      n_commits = n_commits + int'(commit0_o) + int'(commit1_o);
    end
  end

  // Starts and ends at a falling edge. Mode 0 drives a random bundle, 1 holds it and 2 idles
  task automatic drive_cycle(input bit cmp_on, input int mode);
    logic [9:0] e0;
    logic [9:0] e1;
    bit         c0;
    bit         c1;
    bit         hold;
    int         idx;
    areg_t      d0;
    preg_t      r1_pick;
    e0 = '0;
    e1 = '0;
    c0 = cmp_on && (pending.size() > 0) && ($urandom_range(3) != 0);
    if (c0) begin
      idx = $urandom_range(pending.size() - 1);
      e0  = pending[idx];
      pending.delete(idx);
    end
    c1 = cmp_on && (pending.size() > 0) && ($urandom_range(3) != 0);
    if (c1) begin
      idx = $urandom_range(pending.size() - 1);
      e1  = pending[idx];
      pending.delete(idx);
    end
    d0 = ($urandom_range(7) == 0) ? areg_t'(0) : areg_t'($urandom_range(31));
    r1_pick = (pending.size() > 0) ? pending[$urandom_range(pending.size() - 1)][9:4]
                                   : preg_t'($urandom_range(63));
    // A bundle that the engine will refuse stays on the inputs
    hold = valid_i && busy_ref();
    @(posedge core_clock_i);
    cmp0_i      <= c0;
    cmp0_slot_i <= e0[3:0];
    wb0_we_i    <= c0 && (e0[9:4] != 0);
    wb0_dest_i  <= e0[9:4];
    wb0_data_i  <= $urandom();
    cmp1_i      <= c1;
    cmp1_slot_i <= e1[3:0];
    wb1_we_i    <= c1 && (e1[9:4] != 0);
    wb1_dest_i  <= e1[9:4];
    wb1_data_i  <= $urandom();
    r0_preg_i   <= preg_t'($urandom_range(63));
    r1_preg_i   <= r1_pick;
    p0_rd_src_i <= preg_t'($urandom_range(63));
    p1_rd_src_i <= preg_t'($urandom_range(63));
    if (mode == 0) begin
      if (!hold) begin
        valid_i      <= ($urandom_range(3) != 0);
        ins1_valid_i <= ($urandom_range(3) != 0);
        ins0_wr_i    <= ($urandom_range(7) != 0);
        ins1_wr_i    <= ($urandom_range(7) != 0);
        ins0_rs1_i   <= areg_t'($urandom_range(31));
        ins0_rs2_i   <= areg_t'($urandom_range(31));
        ins0_dest_i  <= d0;
        ins1_rs1_i   <= ($urandom_range(1) == 1) ? d0 : areg_t'($urandom_range(31));
        ins1_rs2_i   <= ($urandom_range(3) == 0) ? d0 : areg_t'($urandom_range(31));
        ins1_dest_i  <= ($urandom_range(5) == 0) ? d0 : areg_t'($urandom_range(31));
      end
    end else begin
      valid_i <= (mode == 1);
    end
    @(negedge core_clock_i);
  endtask

  initial begin : stimulus
    void'($urandom(5093));
    core_clock_i = 1'b0;
    reset_i      = 1'b1;
    {valid_i, ins1_valid_i, ins0_wr_i, ins1_wr_i} = '0;
    {ins0_rs1_i, ins0_rs2_i, ins0_dest_i, ins1_rs1_i, ins1_rs2_i, ins1_dest_i} = '0;
    {wb0_we_i, wb1_we_i, cmp0_i, cmp1_i, cmp0_slot_i, cmp1_slot_i} = '0;
    {wb0_dest_i, wb1_dest_i, wb0_data_i, wb1_data_i} = '0;
    {p0_rd_src_i, p1_rd_src_i, r0_preg_i, r1_preg_i} = '0;
    repeat (RST_CYCLES) @(posedge core_clock_i);
    reset_i <= 1'b0;
    @(negedge core_clock_i);
    // Walk all ready bits straight after reset
    for (int i = 0; i < SWEEP_CYCLES; i++) begin
      @(posedge core_clock_i);
      r0_preg_i <= preg_t'(2 * i);
      r1_preg_i <= preg_t'(2 * i + 1);
      @(negedge core_clock_i);
    end
    repeat (RAND_CYCLES) drive_cycle(1'b1, 0);
    // Hold one bundle with no completions until the retire queue fills
    repeat (BP_CYCLES) drive_cycle(1'b0, 1);
    check(rn_busy_o, 1'b1, "rn_busy_o after renames without completion");
    while ((m_rq_count != 0) || (pending.size() != 0)) drive_cycle(1'b1, 2);
    repeat (4) drive_cycle(1'b0, 2);
    check(rn_busy_o, 1'b0, "rn_busy_o after drain");
    check(n_commits, n_insts, "commit pulse count");
    @(posedge core_clock_i);
    $display("Run finished: %0d checks, %0d errors, %0d instructions committed",
             checks, errors, n_commits);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  always @(posedge core_clock_i) begin
    cycles = cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("RESULT: FAIL");
      $finish;
    end
  end

endmodule
